/* chess_pkg.sv */
package chess_pkg;

   // piece code, bit 3 marks black
   typedef logic [3:0] piece_t;
   typedef logic [2:0] kind_t;

   localparam kind_t KIND_EMPTY  = 3'd0;
   localparam kind_t KIND_PAWN   = 3'd1;
   localparam kind_t KIND_KNIGHT = 3'd2;
   localparam kind_t KIND_BISHOP = 3'd3;
   localparam kind_t KIND_ROOK   = 3'd4;
   localparam kind_t KIND_QUEEN  = 3'd5;
   localparam kind_t KIND_KING   = 3'd6;

   localparam int BLACK_BIT = 3;

   localparam piece_t EMPTY_SQUARE = 4'h0;

   localparam int BOARD_SIDE = 8;

   // square 0 is row 0, column 0
   typedef piece_t [63:0] board_t;
   typedef logic [5:0] square_t;

   // one spare bit so a step off either edge stays visible
   typedef logic signed [4:0] coord_t;

   // sliders keep stepping along a ray
   function automatic logic is_slider(kind_t kind);
      return kind == KIND_QUEEN || kind == KIND_ROOK || kind == KIND_BISHOP;
   endfunction

   function automatic square_t square_index(coord_t row, coord_t col);
      return {row[2:0], col[2:0]}; // row * 8 + col
   endfunction

endpackage

/* movegen_pkg.sv */
package movegen_pkg;

   // one stored position, board in the low bits
   typedef struct packed
   {
      logic [3:0]        en_passant_col;
      logic [3:0]        castle_mask;
      logic              white_to_move;
      chess_pkg::board_t board;
   } position_t;

   localparam int MAX_MOVES = 256;

   typedef logic [7:0] move_index_t;

   // king and queen order, row offset then column offset
   localparam chess_pkg::coord_t DIR_ROW_OFFSETS [8] = '{
      -1, -1, -1,  0,  0,  1,  1,  1
   };
   localparam chess_pkg::coord_t DIR_COL_OFFSETS [8] = '{
      -1,  0,  1, -1,  1, -1,  0,  1
   };

   // entries of the direction tables used by rook and bishop
   localparam logic [2:0] ROOK_DIRS [4] = '{3'd1, 3'd3, 3'd4, 3'd6};
   localparam logic [2:0] BISHOP_DIRS [4] = '{3'd0, 3'd2, 3'd5, 3'd7};

   localparam chess_pkg::coord_t KNIGHT_ROW_OFFSETS [8] = '{
      -2, -1,  1,  2,  2,  1, -1, -2
   };
   localparam chess_pkg::coord_t KNIGHT_COL_OFFSETS [8] = '{
      -1, -2, -2, -1,  1,  2,  2,  1
   };

   typedef enum logic [2:0]
   {
      IDLE,
      SCAN,
      DIR_START,
      WALK,
      DONE
   } gen_state_t;

endpackage

/* step_target.sv */
`timescale 1ns/1ps

module step_target
(
   input  chess_pkg::board_t board,
   input  logic              white_to_move,
   input  chess_pkg::kind_t  kind,
   input  logic [2:0]        dir,
   input  chess_pkg::coord_t origin_row,
   input  chess_pkg::coord_t origin_col,
   input  chess_pkg::coord_t walk_row,
   input  chess_pkg::coord_t walk_col,
   output chess_pkg::coord_t next_row,
   output chess_pkg::coord_t next_col,
   output logic              land,
   output logic              capture
);

   logic [2:0]        table_dir;
   chess_pkg::coord_t row_step, col_step;
   chess_pkg::coord_t base_row, base_col;
   chess_pkg::piece_t target;
   logic              on_board, opponent;

   always_comb
   begin
      case (kind)
         chess_pkg::KIND_ROOK:   table_dir = movegen_pkg::ROOK_DIRS[dir[1:0]];
         chess_pkg::KIND_BISHOP: table_dir = movegen_pkg::BISHOP_DIRS[dir[1:0]];
         default:                table_dir = dir;
      endcase
      if (kind == chess_pkg::KIND_KNIGHT)
      begin
         row_step = movegen_pkg::KNIGHT_ROW_OFFSETS[dir];
         col_step = movegen_pkg::KNIGHT_COL_OFFSETS[dir];
      end
      else
      begin
         row_step = movegen_pkg::DIR_ROW_OFFSETS[table_dir];
         col_step = movegen_pkg::DIR_COL_OFFSETS[table_dir];
      end
   end

   // rays continue from the last square, jumps start at the origin
   assign base_row = chess_pkg::is_slider(kind) ? walk_row : origin_row;
   assign base_col = chess_pkg::is_slider(kind) ? walk_col : origin_col;

   assign next_row = base_row + row_step;
   assign next_col = base_col + col_step;

   assign on_board = next_row >= 0 && next_row < chess_pkg::BOARD_SIDE &&
                     next_col >= 0 && next_col < chess_pkg::BOARD_SIDE;

   // only meaningful once on_board holds
   assign target   = board[chess_pkg::square_index(next_row, next_col)];
   assign opponent = target != chess_pkg::EMPTY_SQUARE &&
                     target[chess_pkg::BLACK_BIT] == white_to_move;

   assign land    = on_board && (target == chess_pkg::EMPTY_SQUARE || opponent);
   assign capture = on_board && opponent;

endmodule

/* move_generator.sv */
`timescale 1ns/1ps

module move_generator
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_valid,
   input  movegen_pkg::position_t pos_in,
   input  logic                   clear_moves,
   output logic                   moves_ready,
   output logic                   start,
   output logic                   wr_en,
   output movegen_pkg::position_t wr_pos
);

   movegen_pkg::gen_state_t state;
   movegen_pkg::position_t  pos;
   movegen_pkg::position_t  move_rec;
   chess_pkg::coord_t       row, col;
   chess_pkg::coord_t       walk_row, walk_col;
   chess_pkg::coord_t       next_row, next_col;
   chess_pkg::piece_t       square_piece;
   chess_pkg::piece_t       piece;
   logic [2:0]              dir;
   logic [2:0]              last_dir;
   logic                    land, capture;
   logic                    slider;
   logic                    skip_square;
   logic                    ray_done;
   logic                    last_square;
   logic                    advance;

   assign square_piece = pos.board[chess_pkg::square_index(row, col)];

   // nothing to move for the side to move
   assign skip_square = square_piece[2:0] == chess_pkg::KIND_EMPTY ||
                        square_piece[2:0] == chess_pkg::KIND_PAWN ||
                        square_piece[2:0] > chess_pkg::KIND_KING ||
                        square_piece[chess_pkg::BLACK_BIT] == pos.white_to_move;

   assign slider   = chess_pkg::is_slider(piece[2:0]);
   assign last_dir = (piece[2:0] == chess_pkg::KIND_ROOK ||
                      piece[2:0] == chess_pkg::KIND_BISHOP) ? 3'd3 : 3'd7;

   // jumps try each offset once, rays end on a capture or a blocked square
   assign ray_done    = !land || capture || !slider;
   assign last_square = row == chess_pkg::BOARD_SIDE - 1 && col == chess_pkg::BOARD_SIDE - 1;
   assign advance     = (state == movegen_pkg::SCAN && skip_square) ||
                        (state == movegen_pkg::WALK && ray_done && dir == last_dir);

   step_target u_step
   (
      .board         (pos.board),
      .white_to_move (pos.white_to_move),
      .kind          (piece[2:0]),
      .dir           (dir),
      .origin_row    (row),
      .origin_col    (col),
      .walk_row      (walk_row),
      .walk_col      (walk_col),
      .next_row      (next_row),
      .next_col      (next_col),
      .land          (land),
      .capture       (capture)
   );

   always_comb
   begin
      move_rec = pos;
      move_rec.white_to_move = ~pos.white_to_move;
      move_rec.board[chess_pkg::square_index(row, col)] = chess_pkg::EMPTY_SQUARE;
      move_rec.board[chess_pkg::square_index(next_row, next_col)] = piece;
   end

   always_ff @(posedge clk)
   begin
      if (state == movegen_pkg::IDLE && board_valid)
         pos <= pos_in;
      if (state == movegen_pkg::SCAN)
         piece <= square_piece;
      if (state == movegen_pkg::DIR_START)
      begin
         walk_row <= row; // ray starts at the origin
         walk_col <= col;
      end
      else if (state == movegen_pkg::WALK && land)
      begin
         walk_row <= next_row;
         walk_col <= next_col;
      end
      if (state == movegen_pkg::WALK && land)
         wr_pos <= move_rec;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= movegen_pkg::IDLE;
         moves_ready <= 1'b0;
         start       <= 1'b0;
         wr_en       <= 1'b0;
         row         <= '0;
         col         <= '0;
         dir         <= '0;
      end
      else
      begin
         start <= 1'b0;
         wr_en <= 1'b0;
         case (state)
            movegen_pkg::IDLE:
               if (board_valid)
               begin
                  start <= 1'b1;
                  row   <= '0;
                  col   <= '0;
                  state <= movegen_pkg::SCAN;
               end
            movegen_pkg::SCAN:
               if (!skip_square)
               begin
                  dir   <= '0;
                  state <= movegen_pkg::DIR_START;
               end
            movegen_pkg::DIR_START:
               state <= movegen_pkg::WALK;
            movegen_pkg::WALK:
            begin
               wr_en <= land;
               if (ray_done && dir != last_dir)
               begin
                  dir   <= dir + 3'd1;
                  state <= slider ? movegen_pkg::DIR_START : movegen_pkg::WALK;
               end
            end
            movegen_pkg::DONE:
               if (clear_moves)
               begin
                  moves_ready <= 1'b0;
                  state       <= movegen_pkg::IDLE;
               end
               else
                  moves_ready <= 1'b1;
            default:
               state <= movegen_pkg::IDLE;
         endcase

         // next square in row-major order
         if (advance)
         begin
            if (last_square)
               state <= movegen_pkg::DONE;
            else
            begin
               state <= movegen_pkg::SCAN;
               if (col == chess_pkg::BOARD_SIDE - 1)
               begin
                  row <= row + 5'sd1;
                  col <= '0;
               end
               else
                  col <= col + 5'sd1;
            end
         end
      end
   end

endmodule

/* move_store.sv */
`timescale 1ns/1ps

module move_store
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  logic                     wr_en,
   input  movegen_pkg::position_t   wr_pos,
   input  movegen_pkg::move_index_t rd_index,
   output movegen_pkg::position_t   rd_pos,
   output movegen_pkg::move_index_t count
);

   movegen_pkg::position_t   mem [movegen_pkg::MAX_MOVES];
   movegen_pkg::move_index_t wr_addr;

   assign count = wr_addr; // writes since the last start

   always_ff @(posedge clk)
   begin
      if (reset || start)
         wr_addr <= '0;
      else if (wr_en)
         wr_addr <= wr_addr + 8'd1;
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_pos;
      rd_pos <= mem[rd_index]; // one cycle read latency
   end

endmodule

/* all_moves.sv */
`timescale 1ns/1ps

module all_moves
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     board_valid,
   input  movegen_pkg::position_t   pos_in,
   input  movegen_pkg::move_index_t move_index,
   input  logic                     clear_moves,
   output logic                     moves_ready,
   output movegen_pkg::move_index_t move_count,
   output movegen_pkg::position_t   pos_out
);

   logic                   start;
   logic                   wr_en;
   movegen_pkg::position_t wr_pos;

   // walks the board and streams one record per move
   move_generator u_gen
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .pos_in      (pos_in),
      .clear_moves (clear_moves),
      .moves_ready (moves_ready),
      .start       (start),
      .wr_en       (wr_en),
      .wr_pos      (wr_pos)
   );

   move_store u_store
   (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .wr_en    (wr_en),
      .wr_pos   (wr_pos),
      .rd_index (move_index),
      .rd_pos   (pos_out),
      .count    (move_count)
   );

endmodule

/* tb_ref_model.svh */
// one piece onto a board, square index is row * 8 + col
function automatic chess_pkg::board_t place(chess_pkg::board_t board, int row, int col,
                                            chess_pkg::kind_t kind, logic black);
   board[row * 8 + col] = {black, kind};
   return board;
endfunction

function automatic movegen_pkg::position_t make_position(chess_pkg::board_t board,
                                                         logic white_to_move,
                                                         logic [3:0] castle_mask,
                                                         logic [3:0] en_passant_col);
   movegen_pkg::position_t pos;
   pos.board          = board;
   pos.white_to_move  = white_to_move;
   pos.castle_mask    = castle_mask;
   pos.en_passant_col = en_passant_col;
   return pos;
endfunction

// 0 no move, 1 quiet move, 2 capture
function automatic int try_move(movegen_pkg::position_t pos, int from_sq, int row, int col);
   movegen_pkg::position_t rec;
   chess_pkg::piece_t      mover;
   chess_pkg::piece_t      target;
   int                     to_sq;
   if (row < 0 || row > 7 || col < 0 || col > 7)
      return 0;
   to_sq  = row * 8 + col;
   mover  = pos.board[from_sq];
   target = pos.board[to_sq];
   if (target != chess_pkg::EMPTY_SQUARE && target[3] == mover[3])
      return 0; // blocked by own piece
   rec                = pos;
   rec.white_to_move  = ~pos.white_to_move;
   rec.board[from_sq] = chess_pkg::EMPTY_SQUARE;
   rec.board[to_sq]   = mover;
   expected_q.push_back(rec);
   return (target == chess_pkg::EMPTY_SQUARE) ? 1 : 2;
endfunction

// squares ascending, then directions, then steps outward
function automatic void build_expected(movegen_pkg::position_t pos);
   int                line_row [8] = '{-1, -1, -1, 0, 0, 1, 1, 1};
   int                line_col [8] = '{-1, 0, 1, -1, 1, -1, 0, 1};
   int                jump_row [8] = '{-2, -1, 1, 2, 2, 1, -1, -2};
   int                jump_col [8] = '{-1, -2, -2, -1, 1, 2, 2, 1};
   chess_pkg::piece_t piece;
   chess_pkg::kind_t  kind;
   int                sq, d, row, col, step;
   logic              diagonal;
   expected_q.delete();
   for (sq = 0; sq < 64; sq++)
   begin
      piece = pos.board[sq];
      kind  = piece[2:0];
      row   = sq / 8;
      col   = sq % 8;
      if (piece[3] == pos.white_to_move || kind < chess_pkg::KIND_KNIGHT ||
          kind > chess_pkg::KIND_KING)
         continue; // empty, pawn or opponent
      for (d = 0; d < 8; d++)
      begin
         diagonal = line_row[d] != 0 && line_col[d] != 0;
         case (kind)
            chess_pkg::KIND_KNIGHT: void'(try_move(pos, sq, row + jump_row[d], col + jump_col[d]));
            chess_pkg::KIND_KING:   void'(try_move(pos, sq, row + line_row[d], col + line_col[d]));
            default:
               if (kind == chess_pkg::KIND_QUEEN || (kind == chess_pkg::KIND_ROOK && !diagonal) ||
                   (kind == chess_pkg::KIND_BISHOP && diagonal))
               begin
                  step = 1;
                  while (try_move(pos, sq, row + step * line_row[d],
                                  col + step * line_col[d]) == 1)
                     step++;
               end
         endcase
      end
   end
endfunction

/* tb_all_moves.sv */
`timescale 1ns/1ps

module tb_all_moves;

   localparam int CLK_PERIOD      = 8;
   localparam int RANDOM_BOARDS   = 6;
   localparam int NUM_BOARDS      = 4 + RANDOM_BOARDS;
   localparam int BOARD_CYCLES    = 64 * 80;
   localparam int WATCHDOG_CYCLES = BOARD_CYCLES * NUM_BOARDS + 200;

   logic                     clk;
   logic                     reset;
   logic                     board_valid;
   logic                     clear_moves;
   logic                     moves_ready;
   movegen_pkg::position_t   pos_in;
   movegen_pkg::position_t   pos_out;
   movegen_pkg::move_index_t move_index;
   movegen_pkg::move_index_t move_count;

   movegen_pkg::position_t expected_q [$];
   logic [15:0]            lfsr;
   int                     errors;
   int                     tests_run;
   int                     tests_failed;

   `include "tb_ref_model.svh"

   all_moves u_dut
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .pos_in      (pos_in),
      .move_index  (move_index),
      .clear_moves (clear_moves),
      .moves_ready (moves_ready),
      .move_count  (move_count),
      .pos_out     (pos_out)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   // result held in DONE until cleared
   assert property (@(posedge clk) disable iff (reset) moves_ready && !clear_moves |=> moves_ready)
   else
   begin
      $display("FAIL moves_ready expected 1 got %h", $sampled(moves_ready));
      errors++;
   end

   assert property (@(posedge clk) disable iff (reset) moves_ready && clear_moves |=> !moves_ready)
   else
   begin
      $display("FAIL moves_ready expected 0 got %h", $sampled(moves_ready));
      errors++;
   end

   // 16-bit Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] next_lfsr(logic [15:0] state);
      return state[0] ? (state >> 1) ^ 16'hB400 : state >> 1;
   endfunction

   function automatic int take_bits(int count);
      int value;
      int i;
      value = 0;
      for (i = 0; i < count; i++)
      begin
         value = (value << 1) | lfsr[0];
         lfsr  = next_lfsr(lfsr);
      end
      return value;
   endfunction

   function automatic movegen_pkg::position_t random_position();
      chess_pkg::board_t board;
      int                pieces, n, sq, kind, black, white, castle, ep;
      board  = '0;
      pieces = 3 + take_bits(2);
      for (n = 0; n < pieces; n++)
      begin
         sq    = take_bits(6);
         kind  = chess_pkg::KIND_KNIGHT + take_bits(3) % 5; // knight up to king
         black = take_bits(1);
         board = place(board, sq / 8, sq % 8, chess_pkg::kind_t'(kind), black == 1);
      end
      white  = take_bits(1);
      castle = take_bits(4);
      ep     = take_bits(4);
      return make_position(board, white == 1, 4'(castle), 4'(ep));
   endfunction

   task automatic check_value(string name, int expected, int actual);
      assert (actual == expected)
      else
      begin
         $display("FAIL %s expected %h got %h", name, expected, actual);
         errors++;
      end
   endtask

   // want_count below zero leaves the count to the model alone
   task automatic run_board(movegen_pkg::position_t pos, int want_count);
      int waited;
      int i;
      build_expected(pos);
      @(posedge clk);
      pos_in      <= pos;
      board_valid <= 1'b1;
      @(posedge clk);
      board_valid <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (!moves_ready && waited < BOARD_CYCLES)
      begin
         waited++;
         @(negedge clk);
      end
      assert (moves_ready)
      else
      begin
         $display("moves_ready did not rise within %0d cycles of the board", BOARD_CYCLES);
         errors++;
      end
      if (!moves_ready)
         return;
      // one cycle per square plus one in DONE
      assert (waited >= 65)
      else
      begin
         $display("moves_ready rose after only %0d cycles, before every square", waited);
         errors++;
      end
      check_value("move_count", expected_q.size(), move_count);
      if (want_count >= 0)
         check_value("move_count", want_count, move_count);
      for (i = 0; i < expected_q.size(); i++)
      begin
         @(posedge clk);
         move_index <= movegen_pkg::move_index_t'(i);
         @(posedge clk); // registered read
         @(negedge clk);
         assert (pos_out == expected_q[i])
         else
         begin
            $display("FAIL pos_out[%0d] expected %h got %h", i, expected_q[i], pos_out);
            errors++;
         end
      end
      check_value("move_count", expected_q.size(), move_count); // still stable
   endtask

   task automatic clear_results();
      @(posedge clk);
      clear_moves <= 1'b1;
      @(posedge clk);
      clear_moves <= 1'b0;
      @(negedge clk);
      check_value("moves_ready", 0, moves_ready);
   endtask

   task automatic end_test(string name, int errors_before, int moves);
      tests_run++;
      if (errors == errors_before)
         $display("test %0d %s: ok, %0d moves", tests_run, name, moves);
      else
      begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errors_before);
      end
   endtask

   initial
   begin
      movegen_pkg::position_t pos;
      chess_pkg::board_t      board;
      int                     errors_before;
      int                     n;
      reset        = 1'b1;
      board_valid  = 1'b0;
      clear_moves  = 1'b0;
      pos_in       = '0;
      move_index   = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      lfsr         = 16'd29553;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      errors_before = errors;
      repeat (8)
      begin
         @(negedge clk);
         check_value("moves_ready", 0, moves_ready);
      end
      end_test("idle after reset", errors_before, 0);

      errors_before = errors;
      board = place('0, 0, 0, chess_pkg::KIND_KING, 1'b0);
      run_board(make_position(board, 1'b1, 4'b1011, 4'h5), 3);
      clear_results();
      end_test("corner king", errors_before, expected_q.size());

      // white pieces around a black knight and one on a knight target
      errors_before = errors;
      board = place('0, 3, 3, chess_pkg::KIND_KNIGHT, 1'b1);
      board = place(board, 0, 0, chess_pkg::KIND_ROOK, 1'b0);
      board = place(board, 5, 4, chess_pkg::KIND_BISHOP, 1'b0);
      board = place(board, 7, 7, chess_pkg::KIND_QUEEN, 1'b0);
      board = place(board, 6, 0, chess_pkg::KIND_KING, 1'b0);
      run_board(make_position(board, 1'b0, 4'hf, 4'h3), 8);
      clear_results();
      end_test("black knight", errors_before, expected_q.size());

      errors_before = errors;
      board = place('0, 2, 2, chess_pkg::KIND_ROOK, 1'b0);
      board = place(board, 2, 5, chess_pkg::KIND_PAWN, 1'b0);   // own piece on a rook ray
      board = place(board, 5, 2, chess_pkg::KIND_KNIGHT, 1'b1); // rook capture
      board = place(board, 4, 4, chess_pkg::KIND_BISHOP, 1'b0);
      board = place(board, 6, 6, chess_pkg::KIND_PAWN, 1'b0);
      board = place(board, 2, 6, chess_pkg::KIND_PAWN, 1'b1);   // bishop capture
      run_board(make_position(board, 1'b1, 4'h6, 4'h2), -1);
      clear_results();
      end_test("blocked rays", errors_before, expected_q.size());

      errors_before = errors;
      board = '0;
      for (n = 0; n < 8; n++)
      begin
         board = place(board, 1, n, chess_pkg::KIND_PAWN, 1'b0);
         board = place(board, 6, n, chess_pkg::KIND_PAWN, 1'b1);
      end
      run_board(make_position(board, 1'b1, 4'h0, 4'h0), 0);
      clear_results();
      end_test("pawns only", errors_before, expected_q.size());

      for (n = 0; n < RANDOM_BOARDS; n++)
      begin
         errors_before = errors;
         pos = random_position();
         run_board(pos, -1);
         clear_results();
         end_test("random board", errors_before, expected_q.size());
      end

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
      $display("Errors found");
      $finish;
   end

endmodule

/* tb.f */
+incdir+.
chess_pkg.sv
movegen_pkg.sv
step_target.sv
move_generator.sv
move_store.sv
all_moves.sv
tb_all_moves.sv
